// File: source/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

////////////////////////////////////////
// buffer geometry
////////////////////////////////////////

// bytes in each of the two buffers
`define BUF_BYTES 4096
// byte address width, wraps at BUF_BYTES
`define BYTE_ADDR_W 12
// word address width, four bytes per word
`define WORD_ADDR_W 10

////////////////////////////////////////
// spi side
////////////////////////////////////////

// flops per bus pin before edge detection
`define SYNC_STAGES 2

// word written into every tx location after reset
`define FORMAT_PATTERN 32'h5A6C_C6A5

`endif

// File: source/spiPkg.sv
`include "spi_params.svh"

package spiPkg;

  ////////////////////////////////////////
  // buffer word
  ////////////////////////////////////////

  // one memory word, taken whole or by byte lane
  // lane 0 is the least significant byte
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } memWord_t;

  ////////////////////////////////////////
  // buffer access
  ////////////////////////////////////////

  // byte read request from the spi side, always enabled
  typedef struct packed {
    logic [`BYTE_ADDR_W-1:0] addr;
  } txRead_t;

  // single byte write into the receive buffer
  typedef struct packed {
    logic                    en;
    logic [`BYTE_ADDR_W-1:0] addr;
    logic [7:0]              data;
  } rcWrite_t;

  // whole word write into the transmit buffer
  // used only by the post-reset formatter
  typedef struct packed {
    logic                    en;
    logic [`WORD_ADDR_W-1:0] addr;
    memWord_t                data;
  } wordWrite_t;

endpackage

// File: source/memFormat.sv
`include "spi_params.svh"

module memFormat
  import spiPkg::*;
(
  input  logic       SysClk,
  input  logic       arstN,
  output wordWrite_t wordWrite
);

  ////////////////////////////////////////
  // word sweep
  ////////////////////////////////////////

  // last word index of the tx buffer
  localparam logic [`WORD_ADDR_W-1:0] LastWord = `WORD_ADDR_W'(`BUF_BYTES / 4 - 1);

  logic                    active;
  logic [`WORD_ADDR_W-1:0] wordAddr;

  // one pass over the buffer after each reset
  always_ff @(posedge SysClk or negedge arstN) begin
    if (!arstN) begin
      active   <= 1'b1;
      wordAddr <= '0;
    end else if (active) begin
      // stop after the final word
      if (wordAddr == LastWord) begin
        active <= 1'b0;
      end
      wordAddr <= wordAddr + 1'b1;
    end
  end

  // fixed pattern into every word
  assign wordWrite.en        = active;
  assign wordWrite.addr      = wordAddr;
  assign wordWrite.data.word = `FORMAT_PATTERN;

endmodule

// File: source/txBuffer.sv
`include "spi_params.svh"

module txBuffer
  import spiPkg::*;
(
  input  logic       SysClk,
  input  wordWrite_t wordWrite,
  input  txRead_t    txRead,
  output logic [7:0] txData
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // four bytes per word
  localparam int Words = `BUF_BYTES / 4;

  memWord_t mem [Words];

  // read side split into word and lane
  logic [`WORD_ADDR_W-1:0] rdWordAddr;
  logic [1:0]              rdLane;
  memWord_t                rdWord;

  assign rdWordAddr = txRead.addr[`BYTE_ADDR_W-1:2];
  assign rdLane     = txRead.addr[1:0];
  assign rdWord     = mem[rdWordAddr];

  ////////////////////////////////////////
  // ports
  ////////////////////////////////////////

  // word write from the formatter
  always_ff @(posedge SysClk) begin
    if (wordWrite.en) begin
      mem[wordWrite.addr] <= wordWrite.data;
    end
  end

  // byte read, one cycle after the address
  // lane 0 is the low byte of the word
  always_ff @(posedge SysClk) begin
    txData <= rdWord.bytes[rdLane];
  end

endmodule

// File: source/rcBuffer.sv
`include "spi_params.svh"

module rcBuffer
  import spiPkg::*;
(
  input  logic       SysClk,
  input  logic       arstN,
  input  rcWrite_t   rcWrite,
  output logic [7:0] leds
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  localparam int Words = `BUF_BYTES / 4;

  memWord_t mem [Words];

  // write side split into word and lane
  logic [`WORD_ADDR_W-1:0] wrWordAddr;
  logic [1:0]              wrLane;

  // word before and after the byte merge
  memWord_t oldWord;
  memWord_t newWord;

  assign wrWordAddr = rcWrite.addr[`BYTE_ADDR_W-1:2];
  assign wrLane     = rcWrite.addr[1:0];
  assign oldWord    = mem[wrWordAddr];

  // replace one lane, keep the other three
  always_comb begin
    newWord                = oldWord;
    newWord.bytes[wrLane]  = rcWrite.data;
  end

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge SysClk) begin
    if (rcWrite.en) begin
      mem[wrWordAddr] <= newWord;
    end
  end

  ////////////////////////////////////////
  // led display
  ////////////////////////////////////////

  // byte 0 of the last written word
  // merged value, so a lane 0 write shows at once
  always_ff @(posedge SysClk or negedge arstN) begin
    if (!arstN) begin
      leds <= '0;
    end else if (rcWrite.en) begin
      leds <= newWord.bytes[0];
    end
  end

endmodule

// File: source/spiIfc.sv
`include "spi_params.svh"

module spiIfc
  import spiPkg::*;
(
  input  logic       SysClk,
  input  logic       arstN,
  input  logic       spiSs,
  input  logic       spiMosi,
  input  logic       spiClk,
  output logic       spiMiso,
  output txRead_t    txRead,
  input  logic [7:0] txData,
  output rcWrite_t   rcWrite
);

  ////////////////////////////////////////
  // declarations
  ////////////////////////////////////////

  // synchronizer chains, newest sample in bit 0
  logic [`SYNC_STAGES-1:0] ssSync;
  logic [`SYNC_STAGES-1:0] clkSync;
  logic [`SYNC_STAGES-1:0] mosiSync;

  // synchronized levels
  logic ssS;
  logic clkS;
  logic mosiS;

  // previous synchronized levels for edge detection
  logic ssPrev;
  logic clkPrev;

  // decoded events
  logic ssFall;
  logic clkRise;
  logic clkFall;

  // byte framing
  logic [2:0] bitCnt;
  logic       byteEnd;
  logic [1:0] loadPipe;

  // buffer addresses
  logic [`BYTE_ADDR_W-1:0] txAddr;
  logic [`BYTE_ADDR_W-1:0] rcAddr;

  // shifters
  logic [7:0] txShift;
  logic [7:0] rcShift;
  logic [7:0] rcNext;

  // registered rc write port
  logic                    rcWrEn;
  logic [`BYTE_ADDR_W-1:0] rcWrAddr;
  logic [7:0]              rcWrData;

  ////////////////////////////////////////
  // bus synchronizers
  ////////////////////////////////////////

  // select idles high, clock idles low in mode 0
  always_ff @(posedge SysClk or negedge arstN) begin
    if (!arstN) begin
      ssSync   <= '1;
      clkSync  <= '0;
      mosiSync <= '0;
      ssPrev   <= 1'b1;
      clkPrev  <= 1'b0;
    end else begin
      ssSync   <= {ssSync[`SYNC_STAGES-2:0], spiSs};
      clkSync  <= {clkSync[`SYNC_STAGES-2:0], spiClk};
      mosiSync <= {mosiSync[`SYNC_STAGES-2:0], spiMosi};
      ssPrev   <= ssS;
      clkPrev  <= clkS;
    end
  end

  assign ssS   = ssSync[`SYNC_STAGES-1];
  assign clkS  = clkSync[`SYNC_STAGES-1];
  assign mosiS = mosiSync[`SYNC_STAGES-1];

  // edges only count while selected
  assign ssFall  = ssPrev & ~ssS;
  assign clkRise = ~clkPrev & clkS & ~ssS;
  assign clkFall = clkPrev & ~clkS & ~ssS;

  // next rx byte with the current mosi bit
  assign rcNext = {rcShift[6:0], mosiS};

  ////////////////////////////////////////
  // framing and addresses
  ////////////////////////////////////////

  always_ff @(posedge SysClk or negedge arstN) begin
    if (!arstN) begin
      bitCnt   <= '0;
      byteEnd  <= 1'b0;
      loadPipe <= '0;
      txAddr   <= '0;
      rcAddr   <= '0;
      rcWrEn   <= 1'b0;
    end else begin
      // write strobe lasts one cycle
      rcWrEn   <= 1'b0;
      // byte 0 reaches txData two cycles after the address reset
      loadPipe <= {loadPipe[0], ssFall};
      if (ssFall) begin
        // new transaction, any partial byte is lost here
        txAddr  <= '0;
        rcAddr  <= '0;
        bitCnt  <= '0;
        byteEnd <= 1'b0;
      end else if (clkRise) begin
        bitCnt <= bitCnt + 3'd1;
        if (bitCnt == 3'd7) begin
          rcWrEn  <= 1'b1;
          rcAddr  <= rcAddr + 1'b1;
          // prefetch next tx byte, ready before the falling edge
          txAddr  <= txAddr + 1'b1;
          byteEnd <= 1'b1;
        end
      end else if (clkFall) begin
        byteEnd <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // shifters
  ////////////////////////////////////////

  // miso shifter, cleared so miso is low out of reset
  always_ff @(posedge SysClk or negedge arstN) begin
    if (!arstN) begin
      txShift <= '0;
    end else if (loadPipe[1]) begin
      txShift <= txData;
    end else if (clkFall) begin
      // byte boundary loads instead of shifting
      txShift <= byteEnd ? txData : {txShift[6:0], 1'b0};
    end
  end

  // mosi shifter and write payload
  always_ff @(posedge SysClk) begin
    if (clkRise) begin
      rcShift <= rcNext;
      if (bitCnt == 3'd7) begin
        rcWrAddr <= rcAddr;
        rcWrData <= rcNext;
      end
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // msb first, held after select rises
  assign spiMiso = txShift[7];
  assign txRead  = '{addr: txAddr};
  assign rcWrite = '{en: rcWrEn, addr: rcWrAddr, data: rcWrData};

endmodule

// File: source/spiWrap.sv
module spiWrap
  import spiPkg::*;
(
  input  logic       SysClk,
  input  logic       arstN,
  input  logic       spiSs,
  input  logic       spiMosi,
  input  logic       spiClk,
  output logic       spiMiso,
  output logic [7:0] leds
);

  // formatter to tx buffer
  wordWrite_t wordWrite;

  // spi side buffer traffic
  txRead_t    txRead;
  logic [7:0] txData;
  rcWrite_t   rcWrite;

  ////////////////////////////////////////
  // buffers
  ////////////////////////////////////////

  memFormat u_memFormat (
    .SysClk    (SysClk),
    .arstN     (arstN),
    .wordWrite (wordWrite)
  );

  txBuffer u_txBuffer (
    .SysClk    (SysClk),
    .wordWrite (wordWrite),
    .txRead    (txRead),
    .txData    (txData)
  );

  // received bytes, byte 0 shown on leds
  rcBuffer u_rcBuffer (
    .SysClk  (SysClk),
    .arstN   (arstN),
    .rcWrite (rcWrite),
    .leds    (leds)
  );

  ////////////////////////////////////////
  // spi slave
  ////////////////////////////////////////

  spiIfc u_spiIfc (
    .SysClk  (SysClk),
    .arstN   (arstN),
    .spiSs   (spiSs),
    .spiMosi (spiMosi),
    .spiClk  (spiClk),
    .spiMiso (spiMiso),
    .txRead  (txRead),
    .txData  (txData),
    .rcWrite (rcWrite)
  );

endmodule

// File: bench/clockGen.sv
module clockGen (
  input  logic rstReq,
  output logic SysClk,
  output logic arstN
);

  // power-on reset done flag
  logic porDone;

  // free running clock, period 8
  initial begin
    SysClk = 1'b0;
    forever #4 SysClk = ~SysClk;
  end

  // power-on reset held for 5 cycles, released on a falling edge
  initial begin
    porDone = 1'b0;
    repeat (5) @(posedge SysClk);
    @(negedge SysClk);
    porDone = 1'b1;
  end

  // bench may pull reset again at any time
  assign arstN = porDone & ~rstReq;

endmodule

// File: bench/spiWrapTb.sv
`include "spi_params.svh"

module spiWrapTb;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic       SysClk;
  logic       arstN;
  logic       rstReq;
  logic       spiSs;
  logic       spiMosi;
  logic       spiClk;
  logic       spiMiso;
  logic [7:0] leds;

  // lcg state and mosi bytes of the last transaction
  logic [31:0] lcgState;
  logic [7:0]  sent [$];
  logic [7:0]  prevLeds;

  clockGen u_clockGen (
    .rstReq (rstReq),
    .SysClk (SysClk),
    .arstN  (arstN)
  );

  spiWrap u_spiWrap (
    .SysClk  (SysClk),
    .arstN   (arstN),
    .spiSs   (spiSs),
    .spiMosi (spiMosi),
    .spiClk  (spiClk),
    .spiMiso (spiMiso),
    .leds    (leds)
  );

  ////////////////////////////////////////
  // failure handling and checks
  ////////////////////////////////////////

  task automatic stopOnFailure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkByte(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("mismatch time=%0t signal=%s expected=%02h actual=%02h",
               $time, name, expected, actual);
      stopOnFailure();
    end
  endtask

  ////////////////////////////////////////
  // reference model and stimulus
  ////////////////////////////////////////

  // byte n of the tx buffer, lane 0 is the low byte of the pattern
  function automatic logic [7:0] patternByte(input int n);
    logic [31:0] shifted;
    shifted = `FORMAT_PATTERN >> (8 * (n % 4));
    return shifted[7:0];
  endfunction

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // middle bits, low bits of an lcg are weak
  task automatic nextRandomByte(output logic [7:0] value);
    lcgState = lcgNext(lcgState);
    value    = lcgState[23:16];
  endtask

  ////////////////////////////////////////
  // waits
  ////////////////////////////////////////

  task automatic waitCycles(input int n);
    repeat (n) @(negedge SysClk);
  endtask

  task automatic waitResetRelease(input int timeout);
    int cnt;
    cnt = 0;
    while (arstN !== 1'b1) begin
      if (cnt == timeout) begin
        $display("timeout waiting for reset release after %0d cycles", cnt);
        stopOnFailure();
      end
      @(negedge SysClk);
      cnt++;
    end
  endtask

  ////////////////////////////////////////
  // spi master, mode 0
  ////////////////////////////////////////

  // spiClk half-period in SysClk cycles
  task automatic halfPeriod();
    waitCycles(5);
  endtask

  // msb first, miso sampled just before each rising edge
  task automatic shiftByte(input logic [7:0] mosiByte, input int nBits,
                           output logic [7:0] misoByte);
    logic [7:0] txWork;
    int         i;
    txWork   = mosiByte;
    misoByte = '0;
    for (i = 0; i < nBits; i++) begin
      spiMosi  = txWork[7];
      txWork   = txWork << 1;
      halfPeriod();
      misoByte = {misoByte[6:0], spiMiso};
      spiClk   = 1'b1;
      halfPeriod();
      spiClk   = 1'b0;
    end
  endtask

  // slave needs 8 cycles before the first rising edge
  task automatic selectLow();
    spiSs = 1'b0;
    waitCycles(8);
  endtask

  task automatic selectHigh();
    halfPeriod();
    spiSs = 1'b1;
    waitCycles(10);
  endtask

  // random mosi bytes, miso checked against the pattern
  task automatic runTransaction(input int nBytes);
    logic [7:0] txByte;
    logic [7:0] rxByte;
    int         n;
    sent.delete();
    selectLow();
    for (n = 0; n < nBytes; n++) begin
      nextRandomByte(txByte);
      sent.push_back(txByte);
      shiftByte(txByte, 8, rxByte);
      checkByte("spiMiso", patternByte(n), rxByte);
    end
    selectHigh();
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [7:0] txByte;
    logic [7:0] rxByte;
    lcgState = 32'h7b23efaf;
    rstReq   = 1'b0;
    spiSs    = 1'b1;
    spiMosi  = 1'b0;
    spiClk   = 1'b0;

    // reset values, inside and just after reset
    waitCycles(3);
    checkByte("leds", 8'h00, leds);
    checkByte("spiMiso", 8'h00, {7'b0, spiMiso});
    waitResetRelease(20);
    waitCycles(2);
    checkByte("leds", 8'h00, leds);
    checkByte("spiMiso", 8'h00, {7'b0, spiMiso});

    // formatter needs 1024 cycles
    waitCycles(1100);

    // 12 pattern bytes, last write is word 2 lane 3
    runTransaction(12);
    checkByte("leds", sent[8], leds);

    // received bytes on the leds, last write is word 0 lane 2
    runTransaction(3);
    checkByte("leds", sent[0], leds);

    // restart at byte 0, last write is word 0 lane 3
    // a carried address would start at pattern lane 3
    runTransaction(4);
    checkByte("leds", sent[0], leds);

    // last write is word 1 lane 1, lane 0 holds byte 4
    runTransaction(6);
    checkByte("leds", sent[4], leds);

    // 5 bits then select high, no write
    // leds keep byte 4 of the six byte transaction
    prevLeds = sent[4];
    nextRandomByte(txByte);
    selectLow();
    shiftByte(txByte, 5, rxByte);
    selectHigh();
    checkByte("leds", prevLeds, leds);

    // next transaction still starts at byte 0
    runTransaction(1);
    checkByte("leds", sent[0], leds);

    // reset in the middle of the third byte
    selectLow();
    nextRandomByte(txByte);
    shiftByte(txByte, 8, rxByte);
    nextRandomByte(txByte);
    shiftByte(txByte, 8, rxByte);
    nextRandomByte(txByte);
    shiftByte(txByte, 3, rxByte);
    rstReq = 1'b1;
    waitCycles(2);
    checkByte("leds", 8'h00, leds);
    checkByte("spiMiso", 8'h00, {7'b0, spiMiso});
    spiSs = 1'b1;
    waitCycles(3);
    rstReq = 1'b0;
    waitResetRelease(20);
    checkByte("leds", 8'h00, leds);

    // reformatted buffer reads the pattern again
    waitCycles(1100);
    runTransaction(12);
    checkByte("leds", sent[8], leds);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/spiPkg.sv
source/memFormat.sv
source/txBuffer.sv
source/rcBuffer.sv
source/spiIfc.sv
source/spiWrap.sv
bench/clockGen.sv
bench/spiWrapTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the spiWrap testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

top=spiWrapTb
objDir=obj_dir
logFile=sim.log

rm -rf "$objDir" "$logFile"

echo "building $top"
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module "$top" --Mdir "$objDir" -o "V$top"
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "build failed with status $buildStatus"
  exit 1
fi

echo "running $top"
./"$objDir"/"V$top" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

# the log decides pass or fail
grep -q "TESTBENCH FAILED" "$logFile"
grepStatus=$?
if [ $grepStatus -eq 0 ]; then
  echo "simulation failed"
  exit 1
elif [ $grepStatus -ne 1 ]; then
  echo "could not search $logFile"
  exit 1
fi

if [ $runStatus -ne 0 ]; then
  echo "simulator exited with status $runStatus"
  exit 1
fi

echo "simulation passed"
exit 0
